// ==== verilog/periph_pkg.sv ====
// Shared types and constants for the 8051-style timer and interrupt block
`default_nettype none

package periph_pkg;

    // SFR addresses served by this block
    typedef enum logic [7:0] {
        SFR_TCON = 8'h88,
        SFR_TMOD = 8'h89,
        SFR_TL0  = 8'h8A,
        SFR_TL1  = 8'h8B,
        SFR_TH0  = 8'h8C,
        SFR_TH1  = 8'h8D
    } sfr_addr_e;

    // One SFR byte
    typedef logic [7:0] data_t;

    // Bus request, valid when sel is high together with wr or rd
    typedef struct packed {
        logic       sel;
        logic       wr;
        logic       rd;
        logic [7:0] addr;
        data_t      wdata;
    } sfr_req_t;

    // TMOD M1/M0 field
    // Split mode is not implemented, a timer in that mode holds its value
    typedef enum logic [1:0] {
        MODE_13BIT   = 2'b00,
        MODE_16BIT   = 2'b01,
        MODE_RELOAD8 = 2'b10,
        MODE_SPLIT   = 2'b11
    } timer_mode_e;

    // Control fields of one timer
    // Upper four bits line up with its TMOD nibble
    typedef struct packed {
        logic        gate;
        logic        counter_mode;
        timer_mode_e mode;
        logic        run;
    } timer_cfg_t;

    // TCON bit positions
    localparam int TCON_TF1 = 7;
    localparam int TCON_TR1 = 6;
    localparam int TCON_TF0 = 5;
    localparam int TCON_TR0 = 4;
    localparam int TCON_IE1 = 3;
    localparam int TCON_IT1 = 2;
    localparam int TCON_IE0 = 1;
    localparam int TCON_IT0 = 0;

    // Clocks per machine cycle
    localparam int TICK_DIV = 12;

endpackage

`default_nettype wire

// ==== verilog/sfr_bus.sv ====
// SFR bus decoder with TMOD/TCON storage, write strobes, flag clears and read-back
`timescale 1ns/1ps
`default_nettype none

module sfr_bus (
    input  logic                         clk,
    input  logic                         reset_n,
    input  periph_pkg::sfr_req_t         sfr_req,
    input  periph_pkg::data_t [1:0]      tl,
    input  periph_pkg::data_t [1:0]      th,
    input  logic [1:0]                   tf,
    input  logic [1:0]                   ie,
    input  logic [1:0]                   tf_ack,
    input  logic [1:0]                   ie_ack,
    output periph_pkg::timer_cfg_t [1:0] cfg,
    output logic [1:0]                   it,
    output logic [1:0]                   tl_wr,
    output logic [1:0]                   th_wr,
    output periph_pkg::data_t            wdata,
    output logic [1:0]                   tf_clr,
    output logic [1:0]                   ie_clr,
    output periph_pkg::data_t            rdata
);
    import periph_pkg::*;

    data_t      tmod;
    logic [1:0] tr;
    logic       wr_en;
    logic       rd_en;
    logic       tcon_wr;
    data_t      tcon_rd;
    data_t      rd_mux;

    assign wr_en   = sfr_req.sel & sfr_req.wr;
    assign rd_en   = sfr_req.sel & sfr_req.rd;
    assign tcon_wr = wr_en && (sfr_req.addr == SFR_TCON);

    // Write byte shared by all timer registers
    assign wdata = sfr_req.wdata;

    // Per-timer TL/TH write strobes
    assign tl_wr[0] = wr_en && (sfr_req.addr == SFR_TL0);
    assign tl_wr[1] = wr_en && (sfr_req.addr == SFR_TL1);
    assign th_wr[0] = wr_en && (sfr_req.addr == SFR_TH0);
    assign th_wr[1] = wr_en && (sfr_req.addr == SFR_TH1);

    // TMOD and the TR/IT bits of TCON live here
    // TF and IE bits belong to the timers and ext_int
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tmod <= '0;
            tr   <= '0;
            it   <= '0;
        end else begin
            if (wr_en && (sfr_req.addr == SFR_TMOD)) begin
                tmod <= sfr_req.wdata;
            end
            if (tcon_wr) begin
                tr[0] <= sfr_req.wdata[TCON_TR0];
                tr[1] <= sfr_req.wdata[TCON_TR1];
                it[0] <= sfr_req.wdata[TCON_IT0];
                it[1] <= sfr_req.wdata[TCON_IT1];
            end
        end
    end

    // Timer 0 uses TMOD[3:0], timer 1 TMOD[7:4]
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cfg[i].gate         = tmod[4*i+3];
            cfg[i].counter_mode = tmod[4*i+2];
            cfg[i].mode         = timer_mode_e'(tmod[4*i +: 2]);
            cfg[i].run          = tr[i];
        end
    end

    // Writing 0 to a flag bit clears it, so does the matching ack
    assign tf_clr[0] = (tcon_wr && !sfr_req.wdata[TCON_TF0]) || tf_ack[0];
    assign tf_clr[1] = (tcon_wr && !sfr_req.wdata[TCON_TF1]) || tf_ack[1];
    assign ie_clr[0] = (tcon_wr && !sfr_req.wdata[TCON_IE0]) || ie_ack[0];
    assign ie_clr[1] = (tcon_wr && !sfr_req.wdata[TCON_IE1]) || ie_ack[1];

    // TCON as seen by a read, live flags merged with stored bits
    always_comb begin
        tcon_rd           = '0;
        tcon_rd[TCON_TF1] = tf[1];
        tcon_rd[TCON_TR1] = tr[1];
        tcon_rd[TCON_TF0] = tf[0];
        tcon_rd[TCON_TR0] = tr[0];
        tcon_rd[TCON_IE1] = ie[1];
        tcon_rd[TCON_IT1] = it[1];
        tcon_rd[TCON_IE0] = ie[0];
        tcon_rd[TCON_IT0] = it[0];
    end

    // Read multiplexer, unmapped addresses give 00h
    always_comb begin
        case (sfr_req.addr)
            SFR_TCON: rd_mux = tcon_rd;
            SFR_TMOD: rd_mux = tmod;
            SFR_TL0:  rd_mux = tl[0];
            SFR_TL1:  rd_mux = tl[1];
            SFR_TH0:  rd_mux = th[0];
            SFR_TH1:  rd_mux = th[1];
            default:  rd_mux = '0;
        endcase
    end

    // Read data lands one cycle after rd and holds until the next read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cycle_tick.sv ====
// Machine-cycle tick generator with tick-rate sampling of the counter pins
`timescale 1ns/1ps
`default_nettype none

module cycle_tick #(
    parameter int tick_div = periph_pkg::TICK_DIV
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [1:0] t_pin,
    output logic       tick,
    output logic [1:0] pin_fall
);
    // Divider needs at least two clocks per tick
    localparam int CNT_W = (tick_div > 2) ? $clog2(tick_div) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(tick_div - 1);
    // Tick sits mid-period, first one tick_div/2 clocks out of reset
    localparam logic [CNT_W-1:0] CNT_TICK = CNT_W'(tick_div / 2);

    logic [CNT_W-1:0] div_cnt;
    // Per pin, [0] is the newest sample
    logic [1:0][1:0]  samp;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else if (div_cnt == CNT_LAST) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = (div_cnt == CNT_TICK);

    // Pins are looked at once per machine cycle only
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            samp <= '0;
        end else if (tick) begin
            for (int i = 0; i < 2; i++) begin
                samp[i] <= {samp[i][0], t_pin[i]};
            end
        end
    end

    // High then low seen on two ticks, reported for a single clock
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pin_fall[i] = tick && (samp[i] == 2'b10);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/timer_unit.sv ====
// One timer/counter with TH/TL, 13-bit, 16-bit and 8-bit auto-reload modes and overflow flag
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  periph_pkg::timer_cfg_t cfg,
    input  logic                   gate_pin,
    input  logic                   tick,
    input  logic                   pin_fall,
    input  logic                   tl_wr,
    input  logic                   th_wr,
    input  periph_pkg::data_t      wdata,
    input  logic                   tf_clr,
    output periph_pkg::data_t      tl,
    output periph_pkg::data_t      th,
    output logic                   tf
);
    import periph_pkg::*;

    logic        count_src;
    logic        count_en;
    logic [12:0] sum13;
    logic [15:0] sum16;
    data_t       sum8;
    data_t       tl_next;
    data_t       th_next;
    logic        at_max;
    logic        wrap;

    // Timer mode counts machine cycles, counter mode counts pin falls
    assign count_src = cfg.counter_mode ? pin_fall : tick;

    // With GATE set, a low interrupt pin stops the count
    assign count_en = count_src && cfg.run && (!cfg.gate || gate_pin);

    // Incremented views for each count width
    assign sum13 = {th, tl[4:0]} + 13'd1;
    assign sum16 = {th, tl} + 16'd1;
    assign sum8  = tl + 8'd1;

    // Next TH/TL and the all-ones check for the selected mode
    always_comb begin
        tl_next = tl;
        th_next = th;
        at_max  = 1'b0;
        case (cfg.mode)
            MODE_13BIT: begin
                // TL[4:0] is a 5-bit prescaler below the 8 bits of TH
                // TL[7:5] is left alone
                at_max  = &{th, tl[4:0]};
                tl_next = {tl[7:5], sum13[4:0]};
                th_next = sum13[12:5];
            end
            MODE_16BIT: begin
                at_max  = &{th, tl};
                tl_next = sum16[7:0];
                th_next = sum16[15:8];
            end
            MODE_RELOAD8: begin
                // TH is the reload value and never counts
                at_max  = &tl;
                tl_next = at_max ? th : sum8;
            end
            MODE_SPLIT: begin
                // Not supported, hold everything
                at_max  = 1'b0;
            end
        endcase
    end

    assign wrap = count_en && at_max;

    // A bus write beats a count landing in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tl <= '0;
            th <= '0;
        end else begin
            if (tl_wr) begin
                tl <= wdata;
            end else if (count_en) begin
                tl <= tl_next;
            end
            if (th_wr) begin
                th <= wdata;
            end else if (count_en) begin
                th <= th_next;
            end
        end
    end

    // Overflow flag rises with the wrap, clear has priority
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tf <= 1'b0;
        end else if (tf_clr) begin
            tf <= 1'b0;
        end else if (wrap) begin
            tf <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ext_int.sv ====
// External interrupt pins 0 and 1, synchronized, level or edge triggered, with IE flags
`timescale 1ns/1ps
`default_nettype none

module ext_int (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [1:0] int_n,
    input  logic [1:0] it,
    input  logic [1:0] ie_clr,
    output logic [1:0] ie
);
    // Per pin shift chain of the inverted pin, newest in [0]
    // [1] is the synchronized request level
    // [3:2] are one stage later and feed the edge detector
    logic [1:0][3:0] req_sh;
    logic [1:0]      set_req;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_sh <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                req_sh[i] <= {req_sh[i][2:0], ~int_n[i]};
            end
        end
    end

    // IT=0 follows the low level, IT=1 takes only a new falling edge
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (it[i]) begin
                set_req[i] = req_sh[i][2] && !req_sh[i][3];
            end else begin
                set_req[i] = req_sh[i][1];
            end
        end
    end

    // Flags are sticky until cleared
    // Clear wins, so in level mode a held pin sets the flag again next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ie <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (ie_clr[i]) begin
                    ie[i] <= 1'b0;
                end else if (set_req[i]) begin
                    ie[i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/timer_periph.sv ====
// Timer and external interrupt SFR peripheral, top level
`timescale 1ns/1ps
`default_nettype none

module timer_periph #(
    parameter int tick_div = periph_pkg::TICK_DIV
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  periph_pkg::sfr_req_t sfr_req,
    output periph_pkg::data_t    rdata,
    input  logic [1:0]           tf_ack,
    input  logic [1:0]           ie_ack,
    input  logic [1:0]           t_pin,
    input  logic [1:0]           int_n,
    output logic [1:0]           irq_tf,
    output logic [1:0]           irq_ie
);
    import periph_pkg::*;

    timer_cfg_t [1:0] cfg;
    data_t [1:0]      tl;
    data_t [1:0]      th;
    data_t            wdata;
    logic [1:0]       it;
    logic [1:0]       tl_wr;
    logic [1:0]       th_wr;
    logic [1:0]       tf_clr;
    logic [1:0]       ie_clr;
    logic [1:0]       pin_fall;
    logic             tick;

    // Register file, decode and read-back
    sfr_bus u_sfr_bus (
        .clk     (clk),
        .reset_n (reset_n),
        .sfr_req (sfr_req),
        .tl      (tl),
        .th      (th),
        .tf      (irq_tf),
        .ie      (irq_ie),
        .tf_ack  (tf_ack),
        .ie_ack  (ie_ack),
        .cfg     (cfg),
        .it      (it),
        .tl_wr   (tl_wr),
        .th_wr   (th_wr),
        .wdata   (wdata),
        .tf_clr  (tf_clr),
        .ie_clr  (ie_clr),
        .rdata   (rdata)
    );

    cycle_tick #(
        .tick_div (tick_div)
    ) u_cycle_tick (
        .clk      (clk),
        .reset_n  (reset_n),
        .t_pin    (t_pin),
        .tick     (tick),
        .pin_fall (pin_fall)
    );

    // Timer n is gated by interrupt pin n
    for (genvar i = 0; i < 2; i++) begin : g_timer
        timer_unit u_timer (
            .clk      (clk),
            .reset_n  (reset_n),
            .cfg      (cfg[i]),
            .gate_pin (int_n[i]),
            .tick     (tick),
            .pin_fall (pin_fall[i]),
            .tl_wr    (tl_wr[i]),
            .th_wr    (th_wr[i]),
            .wdata    (wdata),
            .tf_clr   (tf_clr[i]),
            .tl       (tl[i]),
            .th       (th[i]),
            .tf       (irq_tf[i])
        );
    end

    ext_int u_ext_int (
        .clk     (clk),
        .reset_n (reset_n),
        .int_n   (int_n),
        .it      (it),
        .ie_clr  (ie_clr),
        .ie      (irq_ie)
    );

endmodule

`default_nettype wire

// ==== verif/tb_timer_periph.sv ====
// Testbench for the timer peripheral, replays the golden file over the SFR bus and pins
`timescale 1ns/1ps
`default_nettype none

module tb_timer_periph;
    import periph_pkg::*;

    localparam string GOLDEN = "verif/periph_golden.txt";

    logic       clk;
    logic       reset_n;
    sfr_req_t   sfr_req;
    data_t      rdata;
    logic [1:0] tf_ack;
    logic [1:0] ie_ack;
    logic [1:0] t_pin;
    logic [1:0] int_n;
    logic [1:0] irq_tf;
    logic [1:0] irq_ie;

    // One entry per golden line
    logic [7:0] op_q[$];
    int         sel_q[$];
    int         val_q[$];
    int         want_q[$];

    int checks = 0;
    int mismatches = 0;
    int failures = 0;
    int cycles = 0;
    int cycle_limit = 0;

    // tick_div stays at its default of 12
    timer_periph dut (
        .clk     (clk),
        .reset_n (reset_n),
        .sfr_req (sfr_req),
        .rdata   (rdata),
        .tf_ack  (tf_ack),
        .ie_ack  (ie_ack),
        .t_pin   (t_pin),
        .int_n   (int_n),
        .irq_tf  (irq_tf),
        .irq_ie  (irq_ie)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit, armed once the golden file is read
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout, run still going after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
        end
    endtask

    // Comment lines start with #, fields are hex
    task automatic load_golden();
        int         fd;
        int         n;
        int         sel;
        int         val;
        int         want;
        string      line;
        logic [7:0] op;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            failures++;
            $display("Cannot open the golden file %s", GOLDEN);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                op = line.getc(0);
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", sel, val, want);
                if (n == 3) begin
                    op_q.push_back(op);
                    sel_q.push_back(sel);
                    val_q.push_back(val);
                    want_q.push_back(want);
                end else begin
                    failures++;
                    $display("Golden line not understood: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // Single-cycle write strobe
    task automatic bus_write(input logic [7:0] addr, input data_t data);
        @(posedge clk);
        sfr_req <= '{sel: 1'b1, wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(posedge clk);
        sfr_req <= '0;
    endtask

    // rdata is valid the cycle after rd, checked mid-cycle
    task automatic bus_read(input logic [7:0] addr, input data_t want);
        @(posedge clk);
        sfr_req <= '{sel: 1'b1, wr: 1'b0, rd: 1'b1, addr: addr, wdata: 8'h00};
        @(posedge clk);
        sfr_req <= '0;
        @(negedge clk);
        compare($sformatf("rdata @%h", addr), rdata, want);
    endtask

    // sel 0 drives t_pin, sel 1 drives int_n
    task automatic drive_pins(input int sel, input int level, input int hold);
        @(posedge clk);
        if (sel == 0) begin
            t_pin <= level[1:0];
        end else begin
            int_n <= level[1:0];
        end
        repeat (hold) @(posedge clk);
    endtask

    // One-cycle ack, sel 0 for tf_ack and 1 for ie_ack
    task automatic pulse_ack(input int sel, input int bits);
        @(posedge clk);
        if (sel == 0) begin
            tf_ack <= bits[1:0];
        end else begin
            ie_ack <= bits[1:0];
        end
        @(posedge clk);
        tf_ack <= '0;
        ie_ack <= '0;
    endtask

    // Expected value packs {irq_tf, irq_ie}
    task automatic check_irq_after(input int wait_cycles, input int want);
        repeat (wait_cycles) @(posedge clk);
        @(negedge clk);
        compare("irq_tf", {6'b0, irq_tf}, {6'b0, want[3:2]});
        compare("irq_ie", {6'b0, irq_ie}, {6'b0, want[1:0]});
    endtask

    // Bit index into {irq_tf, irq_ie}
    task automatic poll_flag(input int bit_idx, input int bound, input int want);
        logic [3:0] flags;
        int         waited;
        waited = 0;
        checks++;
        @(negedge clk);
        flags = {irq_tf, irq_ie};
        while (flags[bit_idx] !== want[0] && waited < bound) begin
            @(negedge clk);
            flags = {irq_tf, irq_ie};
            waited++;
        end
        if (flags[bit_idx] !== want[0]) begin
            failures++;
            $display("irq bit %0d did not reach %0d within %0d cycles", bit_idx, want[0], bound);
        end
    endtask

    initial begin
        int budget;
        sfr_req = '0;
        tf_ack  = '0;
        ie_ack  = '0;
        t_pin   = '0;
        int_n   = 2'b11;
        reset_n = 1'b0;
        load_golden();
        if (op_q.size() == 0) begin
            failures++;
            $display("No operations found in the golden file");
        end
        // Waits, poll bounds and pin holds, a few cycles per op, then 20% on top
        budget = 0;
        foreach (op_q[i]) begin
            if (op_q[i] == "I" || op_q[i] == "F") begin
                budget += val_q[i];
            end else if (op_q[i] == "P") begin
                budget += want_q[i];
            end
            budget += 3;
        end
        cycle_limit = (budget + 40) * 6 / 5;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": bus_write(sel_q[i][7:0], val_q[i][7:0]);
                "R": bus_read(sel_q[i][7:0], want_q[i][7:0]);
                "P": drive_pins(sel_q[i], val_q[i], want_q[i]);
                "A": pulse_ack(sel_q[i], val_q[i]);
                "I": check_irq_after(val_q[i], want_q[i]);
                "F": poll_flag(sel_q[i], val_q[i], want_q[i]);
                default: begin
                    failures++;
                    $display("Unknown operation %c in the golden file", op_q[i]);
                end
            endcase
        end
        repeat (2) @(posedge clk);
        $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/periph_golden.txt ====
# One operation per line, op then three hex fields
# W addr data 00 | R addr 00 expect | P sel(0 t_pin, 1 int_n) level hold | A sel(0 tf, 1 ie) bits 00
# I 00 cycles {irq_tf,irq_ie} | F bit bound level, bits 3..0 are tf1 tf0 ie1 ie0
# Reset values and read-back
R 88 00 00
R 8D 00 00
W 89 A5 00
R 89 00 A5
W 8A 3C 00
R 8A 00 3C
W 8D C3 00
R 8D 00 C3
W 88 55 00
R 88 00 55
# Timer 0 mode 1 overflow, then ack
W 89 01 00
W 8A F0 00
W 8C FF 00
W 88 10 00
F 02 D8 01
R 88 00 30
A 00 01 00
I 00 00 00
# Timer 1 mode 2 reload
W 89 20 00
W 8D F8 00
W 8B FE 00
W 88 40 00
F 03 24 01
R 8B 00 F8
R 8D 00 F8
# Timer 0 counting five pin falls
W 89 05 00
W 8A 00 00
W 88 10 00
P 00 01 1E
P 00 00 1E
P 00 01 1E
P 00 00 1E
P 00 01 1E
P 00 00 1E
P 00 01 1E
P 00 00 1E
P 00 01 1E
P 00 00 1E
R 8A 00 05
# GATE set with int_n[0] low holds the count
W 89 0D 00
P 01 02 04
P 00 01 1E
P 00 00 1E
P 00 01 1E
P 00 00 1E
R 8A 00 05
# Int 1 edge mode, TCON clear; int 0 level mode re-sets after ack
W 88 04 00
P 01 00 00
F 01 08 01
W 88 04 00
I 00 06 01
A 01 01 00
I 00 00 00
I 00 01 01

// ==== all.f ====
verilog/periph_pkg.sv
verilog/sfr_bus.sv
verilog/cycle_tick.sv
verilog/timer_unit.sv
verilog/ext_int.sv
verilog/timer_periph.sv
verif/tb_timer_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the timer peripheral testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_timer_periph -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
